//--- part_pkg.sv
// Shared definitions for the unbuffered OTP partition
// Widths, OTP error codes, OTP commands and address select
package part_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // OTP read data and digest width
  parameter int BlockWidth = 64;
  // OTP byte address width
  parameter int OtpByteAddrWidth = 11;
  // Macro works on halfwords, so one low address bit is dropped
  parameter int OtpAddrShift = 1;
  // Halfword address width
  parameter int OtpAddrWidth = OtpByteAddrWidth - OtpAddrShift;
  // Bus word address into the software window
  parameter int SwAddrWidth = OtpByteAddrWidth - 2;
  // Size field holds number of halfwords minus one
  parameter int OtpSizeWidth = 2;
  // Minimum popcount of the raw digest for a zeroized partition
  parameter int ZeroizeThreshold = 48;

  //////////////////////////////////////////////////
  // Enums
  //////////////////////////////////////////////////

  // Error codes, shared with the OTP macro
  typedef enum logic [2:0] {
    NoError             = 3'h0,
    MacroError          = 3'h1,
    MacroEccCorrError   = 3'h2,
    MacroEccUncorrError = 3'h3,
    AccessError         = 3'h4,
    CheckFailError      = 3'h5,
    FsmStateError       = 3'h6
  } otp_err_e;

  // OTP read commands, raw skips the ECC check
  typedef enum logic {
    Read    = 1'b0,
    ReadRaw = 1'b1
  } otp_cmd_e;

  // Select between digest and data word address
  typedef enum logic {
    DigestAddrSel = 1'b0,
    DataAddrSel   = 1'b1
  } addr_sel_e;

endpackage : part_pkg

//--- part_fsm.sv
`timescale 1ns/1ps
// Partition FSM for the unbuffered OTP partition
// Runs the zeroize and digest init reads, serves bus reads,
// latches OTP error codes and handles escalation
module part_fsm (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                init_req_i,
  input  logic                escalate_en_i,
  input  logic                tlul_req_i,
  input  logic                otp_gnt_i,
  input  logic                otp_rvalid_i,
  input  part_pkg::otp_err_e  otp_err_i,
  input  logic                in_range_i,
  input  logic                read_lock_i,
  input  logic                init_zeroized_i,
  output logic                init_done_o,
  output part_pkg::otp_err_e  error_o,
  output logic                fsm_err_o,
  output logic                tlul_gnt_o,
  output logic                tlul_rvalid_o,
  output logic [1:0]          tlul_rerror_o,
  output logic                otp_req_o,
  output part_pkg::otp_cmd_e  otp_cmd_o,
  output part_pkg::addr_sel_e addr_sel_o,
  output logic                chk_zer_en_o,
  output logic                digest_en_o
);
  import part_pkg::*;

  typedef enum logic [3:0] {
    Reset, InitChkZer, InitChkZerWait, Init, InitWait, Idle, Read, ReadWait, Error
  } state_e;

  state_e   state_d, state_q;
  otp_err_e error_d, error_q;
  // Bus error still owed in the error state
  logic     pend_err_d, pend_err_q;
  // Response errors that let the sequence go on
  logic     soft_err;

  assign soft_err = otp_err_i inside {NoError, MacroEccCorrError};
  assign error_o  = error_q;

  //////////////////////////////////////////////////
  // Next state and outputs
  //////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    error_d       = error_q;
    pend_err_d    = 1'b0;
    init_done_o   = 1'b0;
    fsm_err_o     = 1'b0;
    tlul_gnt_o    = 1'b0;
    tlul_rvalid_o = 1'b0;
    tlul_rerror_o = 2'b00;
    otp_req_o     = 1'b0;
    otp_cmd_o     = part_pkg::Read;
    addr_sel_o    = DigestAddrSel;
    chk_zer_en_o  = 1'b0;
    digest_en_o   = 1'b0;

    unique case (state_q)
      // Wait for the one init pulse
      Reset: begin
        if (init_req_i) begin
          state_d = InitChkZer;
        end
      end
      // Raw digest read, only to count set bits
      InitChkZer: begin
        otp_req_o = 1'b1;
        otp_cmd_o = part_pkg::ReadRaw;
        if (otp_gnt_i) begin
          state_d = InitChkZerWait;
        end
      end
      InitChkZerWait: begin
        if (otp_rvalid_i) begin
          if (soft_err) begin
            chk_zer_en_o = 1'b1;
            state_d      = Init;
            if (otp_err_i != NoError) error_d = otp_err_i;
          end else begin
            state_d = Error;
            error_d = otp_err_i;
          end
        end
      end
      // Digest read, ECC off for a zeroized partition
      Init: begin
        otp_req_o = 1'b1;
        if (init_zeroized_i) begin
          otp_cmd_o = part_pkg::ReadRaw;
        end
        if (otp_gnt_i) begin
          state_d = InitWait;
        end
      end
      InitWait: begin
        if (otp_rvalid_i) begin
          digest_en_o = 1'b1;
          if (soft_err) begin
            state_d = Idle;
            if (otp_err_i != NoError) error_d = otp_err_i;
          end else begin
            state_d = Error;
            error_d = otp_err_i;
          end
        end
      end
      // Grant a bus read, soft errors clear here
      Idle: begin
        init_done_o = 1'b1;
        if (tlul_req_i) begin
          tlul_gnt_o = 1'b1;
          error_d    = NoError;
          state_d    = Read;
        end
      end
      // Range and lock check, fault answers right away
      Read: begin
        init_done_o = 1'b1;
        if (in_range_i && !read_lock_i) begin
          otp_req_o  = 1'b1;
          addr_sel_o = DataAddrSel;
          if (otp_gnt_i) begin
            state_d = ReadWait;
          end
        end else begin
          tlul_rvalid_o = 1'b1;
          tlul_rerror_o = 2'b11;
          error_d       = AccessError;
          state_d       = Idle;
        end
      end
      ReadWait: begin
        init_done_o = 1'b1;
        if (otp_rvalid_i) begin
          tlul_rvalid_o = 1'b1;
          if (soft_err) begin
            state_d = Idle;
            if (otp_err_i != NoError) error_d = otp_err_i;
          end else begin
            tlul_rerror_o = 2'b11;
            state_d       = Error;
            error_d       = otp_err_i;
          end
        end
      end
      // Terminal state, every request ends in a bus error
      Error: begin
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
        if (pend_err_q) begin
          tlul_rvalid_o = 1'b1;
          tlul_rerror_o = 2'b11;
        end else if (tlul_req_i) begin
          tlul_gnt_o = 1'b1;
          pend_err_d = 1'b1;
        end
      end
      default: begin
        state_d   = Error;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation wins over everything
    if (escalate_en_i) begin
      state_d   = Error;
      fsm_err_o = 1'b1;
      if (state_q != Error) error_d = FsmStateError;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= Reset;
      error_q    <= NoError;
      pend_err_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      error_q    <= error_d;
      pend_err_q <= pend_err_d;
    end
  end

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // Uncorrectable data error locks the partition
  UncorrErrorState_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == ReadWait && otp_rvalid_i && otp_err_i == MacroEccUncorrError
    |=> state_q == Error)
    else $error("Uncorrectable read error did not reach the error state");

  // Read-locked grant must come back as a bus error
  ReadLockBusError_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tlul_gnt_o ##1 read_lock_i |-> tlul_rvalid_o && tlul_rerror_o == 2'b11)
    else $error("Read-locked access returned no bus error");

endmodule : part_fsm

//--- part_addr_gen.sv
`timescale 1ns/1ps
// Address path of the unbuffered OTP partition
// Latches the bus word address, checks the partition range
// and forms the halfword OTP address and size
module part_addr_gen #(
  parameter int unsigned PartOffset = 0,
  parameter int unsigned PartSize   = 64
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               load_i,
  input  logic [part_pkg::SwAddrWidth-1:0]   tlul_addr_i,
  input  part_pkg::addr_sel_e                addr_sel_i,
  output logic                               in_range_o,
  output logic [part_pkg::OtpAddrWidth-1:0]  otp_addr_o,
  output logic [part_pkg::OtpSizeWidth-1:0]  otp_size_o
);
  import part_pkg::*;

  localparam int unsigned BlockBytes    = BlockWidth / 8;
  localparam int unsigned HalfwordWidth = 16;
  // One extra bit so a partition ending at the top still compares right
  localparam logic [OtpByteAddrWidth:0] PartStart = (OtpByteAddrWidth+1)'(PartOffset);
  localparam logic [OtpByteAddrWidth:0] PartEnd   = (OtpByteAddrWidth+1)'(PartOffset + PartSize);
  // Digest is the last block of the partition
  localparam logic [OtpByteAddrWidth-1:0] DigestOffset =
      OtpByteAddrWidth'(PartOffset + PartSize - BlockBytes);
  localparam logic [OtpSizeWidth-1:0] DigestSize = OtpSizeWidth'(BlockWidth / HalfwordWidth - 1);
  localparam logic [OtpSizeWidth-1:0] WordSize   = OtpSizeWidth'(32 / HalfwordWidth - 1);

  logic [SwAddrWidth-1:0]      addr_q;
  logic [OtpByteAddrWidth-1:0] byte_addr;
  logic [OtpByteAddrWidth-1:0] addr_calc;

  // Word address taken on the bus grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else if (load_i) begin
      addr_q <= tlul_addr_i;
    end
  end

  assign byte_addr  = {addr_q, 2'b00};
  assign in_range_o = ({1'b0, byte_addr} >= PartStart) && ({1'b0, byte_addr} < PartEnd);

  // Drop the halfword bit for the macro
  assign addr_calc  = (addr_sel_i == DigestAddrSel) ? DigestOffset : byte_addr;
  assign otp_addr_o = addr_calc[OtpByteAddrWidth-1:OtpAddrShift];
  assign otp_size_o = (addr_sel_i == DigestAddrSel) ? DigestSize : WordSize;

  initial begin
    OffsetAligned_A: assert (PartOffset % BlockBytes == 0)
      else $error("PartOffset is not block aligned");
    SizeAligned_A: assert (PartSize % BlockBytes == 0)
      else $error("PartSize is not block aligned");
  end

endmodule : part_addr_gen

//--- part_init_capture.sv
`timescale 1ns/1ps
// Init capture of the unbuffered OTP partition
// Holds the sticky zeroized flag and the digest register
module part_init_capture (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             chk_zer_en_i,
  input  logic                             digest_en_i,
  input  logic [part_pkg::BlockWidth-1:0]  otp_rdata_i,
  output logic                             init_zeroized_o,
  output logic [part_pkg::BlockWidth-1:0]  digest_o
);
  import part_pkg::*;

  logic zeroized_q;
  // Set once the digest has been taken, watched by the check below
  logic loaded_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      zeroized_q <= 1'b0;
      loaded_q   <= 1'b0;
      digest_o   <= '0;
    end else begin
      // Mostly set bits means the digest was zeroized
      if (chk_zer_en_i && ($countones(otp_rdata_i) >= ZeroizeThreshold)) begin
        zeroized_q <= 1'b1;
      end
      if (digest_en_i) begin
        digest_o <= otp_rdata_i;
        loaded_q <= 1'b1;
      end
    end
  end

  assign init_zeroized_o = zeroized_q;

  // Digest holds still for the rest of the power cycle
  DigestStable_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    loaded_q |=> $stable(digest_o))
    else $error("Digest changed after init");

endmodule : part_init_capture

//--- part_access_ctrl.sv
`timescale 1ns/1ps
// Access control of the unbuffered OTP partition
// Registers the read and write locks from the incoming locks,
// missing init and, where enabled, a programmed digest
module part_access_ctrl #(
  parameter bit ReadLockByDigest  = 1'b0,
  parameter bit WriteLockByDigest = 1'b1
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             init_done_i,
  input  logic [part_pkg::BlockWidth-1:0]  digest_i,
  input  logic                             read_lock_i,
  input  logic                             write_lock_i,
  output logic                             read_lock_o,
  output logic                             write_lock_o
);
  // Bit 1 write lock, bit 0 read lock
  localparam logic [1:0] ByDigest = {WriteLockByDigest, ReadLockByDigest};

  logic       digest_set;
  logic [1:0] lock_d, lock_q;

  assign digest_set = |digest_i;
  // Uninitialized partition is always locked
  assign lock_d = {write_lock_i, read_lock_i} | {2{~init_done_i}} | (ByDigest & {2{digest_set}});

  // Locks come out of reset closed
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q <= 2'b11;
    end else begin
      lock_q <= lock_d;
    end
  end

  assign read_lock_o  = lock_q[0];
  assign write_lock_o = lock_q[1];

  // Incoming locks show up one cycle later
  LockPropagation_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (read_lock_i |=> read_lock_o) and (write_lock_i |=> write_lock_o))
    else $error("Incoming lock not propagated");

  InitLocks_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !init_done_i |=> read_lock_o && write_lock_o)
    else $error("Partition open before init");

endmodule : part_access_ctrl

//--- part_unbuf_top.sv
`timescale 1ns/1ps
// Unbuffered read-only OTP partition
// Init sequencing, address checks, digest capture and locks
module part_unbuf_top #(
  parameter int unsigned PartOffset        = 64,
  parameter int unsigned PartSize          = 64,
  parameter bit          ReadLockByDigest  = 1'b0,
  parameter bit          WriteLockByDigest = 1'b1
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               init_req_i,
  input  logic                               escalate_en_i,
  input  logic                               read_lock_i,
  input  logic                               write_lock_i,
  input  logic                               tlul_req_i,
  input  logic [part_pkg::SwAddrWidth-1:0]   tlul_addr_i,
  input  logic                               otp_gnt_i,
  input  logic                               otp_rvalid_i,
  input  logic [part_pkg::BlockWidth-1:0]    otp_rdata_i,
  input  part_pkg::otp_err_e                 otp_err_i,
  output logic                               init_done_o,
  output logic                               init_zeroized_o,
  output part_pkg::otp_err_e                 error_o,
  output logic                               fsm_err_o,
  output logic                               read_lock_o,
  output logic                               write_lock_o,
  output logic [part_pkg::BlockWidth-1:0]    digest_o,
  output logic                               tlul_gnt_o,
  output logic                               tlul_rvalid_o,
  output logic [1:0]                         tlul_rerror_o,
  output logic [31:0]                        tlul_rdata_o,
  output logic                               otp_req_o,
  output part_pkg::otp_cmd_e                 otp_cmd_o,
  output logic [part_pkg::OtpAddrWidth-1:0]  otp_addr_o,
  output logic [part_pkg::OtpSizeWidth-1:0]  otp_size_o
);
  import part_pkg::*;

  addr_sel_e addr_sel;
  logic      in_range;
  logic      chk_zer_en;
  logic      digest_en;

  //////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////

  part_fsm u_fsm (
    .clk_i, .rst_ni, .init_req_i, .escalate_en_i, .tlul_req_i,
    .otp_gnt_i, .otp_rvalid_i, .otp_err_i,
    .in_range_i      (in_range),
    .read_lock_i     (read_lock_o),
    .init_zeroized_i (init_zeroized_o),
    .init_done_o, .error_o, .fsm_err_o,
    .tlul_gnt_o, .tlul_rvalid_o, .tlul_rerror_o,
    .otp_req_o, .otp_cmd_o,
    .addr_sel_o      (addr_sel),
    .chk_zer_en_o    (chk_zer_en),
    .digest_en_o     (digest_en)
  );

  part_addr_gen #(.PartOffset(PartOffset), .PartSize(PartSize)) u_addr_gen (
    .clk_i, .rst_ni,
    .load_i     (tlul_gnt_o),
    .tlul_addr_i,
    .addr_sel_i (addr_sel),
    .in_range_o (in_range),
    .otp_addr_o, .otp_size_o
  );

  part_init_capture u_init_capture (
    .clk_i, .rst_ni,
    .chk_zer_en_i (chk_zer_en),
    .digest_en_i  (digest_en),
    .otp_rdata_i, .init_zeroized_o, .digest_o
  );

  part_access_ctrl #(
    .ReadLockByDigest  (ReadLockByDigest),
    .WriteLockByDigest (WriteLockByDigest)
  ) u_access_ctrl (
    .clk_i, .rst_ni,
    .init_done_i (init_done_o),
    .digest_i    (digest_o),
    .read_lock_i, .write_lock_i, .read_lock_o, .write_lock_o
  );

  // No data leaves on an error response
  assign tlul_rdata_o = (tlul_rvalid_o && tlul_rerror_o == 2'b00) ? otp_rdata_i[31:0] : '0;

endmodule : part_unbuf_top

//--- otp_model.sv
`timescale 1ns/1ps
// OTP macro model for the partition testbench
// Halfword array with a random grant delay and error injection
module otp_model (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              req_i,
  input  logic [part_pkg::OtpAddrWidth-1:0] addr_i,
  input  logic                              inject_err_i,
  output logic                              gnt_o,
  output logic                              rvalid_o,
  output logic [part_pkg::BlockWidth-1:0]   rdata_o,
  output part_pkg::otp_err_e                err_o
);
  import part_pkg::*;

  // 256 bytes of OTP, enough for the partition under test
  logic [15:0] mem [128];
  logic [1:0]  dly_q;
  logic        busy_q;
  // Next response carries an uncorrectable error
  logic        armed_q;
  logic [6:0]  addr_q;

  // Odd multiplier keeps every halfword distinct
  initial begin
    for (int i = 0; i < 128; i++) begin
      mem[i] = 16'h5a00 ^ (16'(i) * 16'h0d13);
    end
  end

  assign gnt_o = req_i && !busy_q && (dly_q == 2'd0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dly_q    <= 2'd0;
      busy_q   <= 1'b0;
      armed_q  <= 1'b0;
      addr_q   <= '0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      err_o    <= NoError;
    end else begin
      rvalid_o <= 1'b0;
      if (inject_err_i) begin
        armed_q <= 1'b1;
      end
      if (gnt_o) begin
        busy_q <= 1'b1;
        addr_q <= addr_i[6:0];
        // Fresh delay before the next grant
        dly_q  <= 2'($urandom % 4);
      end else if (req_i && dly_q != 2'd0) begin
        dly_q <= dly_q - 2'd1;
      end
      // One response per grant, one cycle after it
      if (busy_q) begin
        busy_q   <= 1'b0;
        rvalid_o <= 1'b1;
        rdata_o  <= {mem[addr_q + 7'd3], mem[addr_q + 7'd2], mem[addr_q + 7'd1], mem[addr_q]};
        err_o    <= armed_q ? MacroEccUncorrError : NoError;
        armed_q  <= 1'b0;
      end
    end
  end

endmodule : otp_model

//--- tb_part_unbuf.sv
`timescale 1ns/1ps
// Testbench for the unbuffered OTP partition
// Covers init, bus reads, locks, ECC errors and escalation
module tb_part_unbuf;
  import part_pkg::*;

  localparam int unsigned PartOffset = 64;
  localparam int unsigned PartSize   = 64;
  localparam int          WaitLimit  = 100;
  // Digest is the last block, counted in halfwords
  localparam int          DigestHw   = (PartOffset + PartSize - 8) / 2;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    init_req, escalate, read_lock_in, write_lock_in;
  logic                    tlul_req, inject_err;
  logic [SwAddrWidth-1:0]  tlul_addr;
  logic                    otp_gnt, otp_rvalid, otp_req;
  logic [BlockWidth-1:0]   otp_rdata, digest;
  otp_err_e                otp_err, error;
  otp_cmd_e                otp_cmd;
  logic [OtpAddrWidth-1:0] otp_addr;
  logic [OtpSizeWidth-1:0] otp_size;
  logic                    init_done, zeroized, fsm_err, read_lock, write_lock;
  logic                    tlul_gnt, tlul_rvalid;
  logic [1:0]              tlul_rerror;
  logic [31:0]             tlul_rdata;
  int                      err_cnt;
  int                      to_cnt;
  // OTP grants taken during init, the first one is the zeroize read
  int                      init_grants;
  // Zeroized state that the model digest calls for
  logic                    exp_zeroized;
  otp_cmd_e                exp_cmd;

  always #4 clk_i = ~clk_i;

  part_unbuf_top #(
    .PartOffset (PartOffset), .PartSize (PartSize),
    .ReadLockByDigest (1'b0), .WriteLockByDigest (1'b1)
  ) dut (
    .clk_i, .rst_ni, .init_req_i (init_req), .escalate_en_i (escalate),
    .read_lock_i (read_lock_in), .write_lock_i (write_lock_in),
    .tlul_req_i (tlul_req), .tlul_addr_i (tlul_addr),
    .otp_gnt_i (otp_gnt), .otp_rvalid_i (otp_rvalid), .otp_rdata_i (otp_rdata),
    .otp_err_i (otp_err), .init_done_o (init_done), .init_zeroized_o (zeroized),
    .error_o (error), .fsm_err_o (fsm_err), .read_lock_o (read_lock),
    .write_lock_o (write_lock), .digest_o (digest), .tlul_gnt_o (tlul_gnt),
    .tlul_rvalid_o (tlul_rvalid), .tlul_rerror_o (tlul_rerror), .tlul_rdata_o (tlul_rdata),
    .otp_req_o (otp_req), .otp_cmd_o (otp_cmd), .otp_addr_o (otp_addr), .otp_size_o (otp_size)
  );

  otp_model u_otp (
    .clk_i, .rst_ni, .req_i (otp_req), .addr_i (otp_addr), .inject_err_i (inject_err),
    .gnt_o (otp_gnt), .rvalid_o (otp_rvalid), .rdata_o (otp_rdata), .err_o (otp_err)
  );

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      init_grants <= 0;
    end else if (otp_req && otp_gnt && !init_done) begin
      init_grants <= init_grants + 1;
    end
  end

  // Zeroize read is raw, digest read is raw only when zeroized,
  // bus reads go through ECC
  always_comb begin
    if (!init_done && (init_grants == 0 || exp_zeroized)) begin
      exp_cmd = ReadRaw;
    end else begin
      exp_cmd = Read;
    end
  end

  //////////////////////////////////////////////////
  // Protocol checks
  //////////////////////////////////////////////////

  // Error responses carry no data
  RdataClear_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tlul_rvalid && tlul_rerror != 2'b00 |-> tlul_rdata == '0)
    else begin
      err_cnt++;
      $display("Mismatch tlul_rdata_o: got %h, expected %h", $sampled(tlul_rdata), 32'h0);
    end

  // After init the read lock is the incoming lock one cycle late
  ReadLockFollow_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(init_done) |-> read_lock == $past(read_lock_in))
    else begin
      err_cnt++;
      $display("Mismatch read_lock_o: got %h, expected %h",
               $sampled(read_lock), !$sampled(read_lock));
    end

  // Programmed digest keeps writes locked
  WriteLockDigest_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(init_done) && $past(digest) != '0 |-> write_lock)
    else begin
      err_cnt++;
      $display("Mismatch write_lock_o: got %h, expected %h", $sampled(write_lock), 1'b1);
    end

  // Init reads fetch four halfwords of digest, bus reads two
  OtpSize_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    otp_req |-> otp_size == (init_done ? 2'd1 : 2'd3))
    else begin
      err_cnt++;
      $display("Mismatch otp_size_o: got %h, expected %h",
               $sampled(otp_size), $sampled(init_done) ? 2'd1 : 2'd3);
    end

  OtpCmd_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    otp_req |-> otp_cmd == exp_cmd)
    else begin
      err_cnt++;
      $display("Mismatch otp_cmd_o: got %h, expected %h", $sampled(otp_cmd), $sampled(exp_cmd));
    end

  task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("Mismatch %s: got %h, expected %h", what, got, exp);
    end
  endtask

  task automatic note_timeout(input string what);
    to_cnt++;
    $display("Timed out waiting for %s", what);
  endtask

  function automatic int count_bits(input logic [63:0] value);
    int n;
    n = 0;
    for (int i = 0; i < 64; i++) begin
      n += int'(value[i]);
    end
    return n;
  endfunction

  // Halfword index is twice the bus word address
  function automatic logic [31:0] model_word(input logic [8:0] addr);
    logic [6:0] hw;
    hw = 7'({addr, 1'b0});
    return {u_otp.mem[hw + 7'd1], u_otp.mem[hw]};
  endfunction

  function automatic logic [63:0] model_digest();
    return {u_otp.mem[DigestHw + 3], u_otp.mem[DigestHw + 2],
            u_otp.mem[DigestHw + 1], u_otp.mem[DigestHw]};
  endfunction

  task automatic load_digest(input logic [63:0] value);
    for (int k = 0; k < 4; k++) begin
      u_otp.mem[DigestHw + k] = value[16*k +: 16];
    end
  endtask

  task automatic reset_dut();
    @(posedge clk_i);
    rst_ni <= 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
  endtask

  // Init pulse, locks must stay closed until done
  task automatic run_init();
    int cnt;
    cnt = 0;
    @(posedge clk_i);
    init_req <= 1'b1;
    @(posedge clk_i);
    init_req <= 1'b0;
    @(negedge clk_i);
    while (!init_done && cnt < WaitLimit) begin
      check_eq("read_lock_o", read_lock, 1'b1);
      check_eq("write_lock_o", write_lock, 1'b1);
      @(negedge clk_i);
      cnt++;
    end
    if (!init_done) begin
      note_timeout("init_done_o");
    end
  endtask

  // One bus read, lat counts cycles from grant to rvalid
  task automatic bus_read(input logic [8:0] addr, output logic [1:0] rerr,
                          output logic [31:0] rdata, output int lat);
    int   cnt;
    logic granted;
    cnt   = 0;
    rerr  = 2'b00;
    rdata = '0;
    lat   = 0;
    @(posedge clk_i);
    tlul_req  <= 1'b1;
    tlul_addr <= addr;
    @(negedge clk_i);
    while (!tlul_gnt && cnt < WaitLimit) begin
      @(negedge clk_i);
      cnt++;
    end
    granted = tlul_gnt;
    @(posedge clk_i);
    tlul_req <= 1'b0;
    if (!granted) begin
      note_timeout("tlul_gnt_o");
      return;
    end
    lat = 1;
    @(negedge clk_i);
    while (!tlul_rvalid && lat < WaitLimit) begin
      @(negedge clk_i);
      lat++;
    end
    if (!tlul_rvalid) begin
      note_timeout("tlul_rvalid_o");
    end
    rerr  = tlul_rerror;
    rdata = tlul_rdata;
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    logic [1:0]  rerr;
    logic [31:0] rdata;
    int          lat;
    logic [8:0]  addr;
    void'($urandom(32'h9cdc));
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    init_req      = 1'b0;
    escalate      = 1'b0;
    read_lock_in  = 1'b0;
    write_lock_in = 1'b0;
    tlul_req      = 1'b0;
    tlul_addr     = '0;
    inject_err    = 1'b0;
    err_cnt       = 0;
    to_cnt        = 0;
    exp_zeroized  = 1'b0;

    // Init with a sparse digest, not zeroized
    reset_dut();
    load_digest(64'h0123_4567_89ab_cdef);
    exp_zeroized = count_bits(model_digest()) >= ZeroizeThreshold;
    run_init();
    check_eq("digest_o", digest, model_digest());
    check_eq("init_zeroized_o", zeroized, exp_zeroized);
    @(negedge clk_i);
    check_eq("write_lock_o", write_lock, 1'b1);
    check_eq("read_lock_o", read_lock, 1'b0);

    // Good reads inside the window
    for (int i = 0; i < 4; i++) begin
      addr = 9'(PartOffset / 4 + $urandom % (PartSize / 4));
      bus_read(addr, rerr, rdata, lat);
      check_eq("tlul_rerror_o", rerr, 2'b00);
      check_eq("tlul_rdata_o", rdata, model_word(addr));
    end

    // Out of range, then read locked
    bus_read(9'd4, rerr, rdata, lat);
    check_eq("tlul_rerror_o", rerr, 2'b11);
    check_eq("tlul_rdata_o", rdata, 32'h0);
    check_eq("rvalid latency", lat, 1);
    @(negedge clk_i);
    check_eq("error_o", error, AccessError);
    @(posedge clk_i);
    read_lock_in <= 1'b1;
    bus_read(9'd20, rerr, rdata, lat);
    check_eq("tlul_rerror_o", rerr, 2'b11);
    check_eq("rvalid latency", lat, 1);
    @(negedge clk_i);
    check_eq("error_o", error, AccessError);
    @(posedge clk_i);
    read_lock_in <= 1'b0;
    repeat (2) @(posedge clk_i);

    // Uncorrectable ECC error ends in the error state
    inject_err <= 1'b1;
    @(posedge clk_i);
    inject_err <= 1'b0;
    bus_read(9'd18, rerr, rdata, lat);
    check_eq("tlul_rerror_o", rerr, 2'b11);
    @(negedge clk_i);
    check_eq("error_o", error, MacroEccUncorrError);
    repeat (2) begin
      bus_read(9'd18, rerr, rdata, lat);
      check_eq("tlul_rerror_o", rerr, 2'b11);
      check_eq("rvalid latency", lat, 1);
    end

    // All-ones digest marks the partition zeroized
    load_digest('1);
    exp_zeroized = count_bits(model_digest()) >= ZeroizeThreshold;
    reset_dut();
    run_init();
    check_eq("init_zeroized_o", zeroized, exp_zeroized);
    check_eq("digest_o", digest, model_digest());

    // Escalation after a fresh init
    reset_dut();
    run_init();
    @(posedge clk_i);
    escalate <= 1'b1;
    @(negedge clk_i);
    check_eq("fsm_err_o", fsm_err, 1'b1);
    @(posedge clk_i);
    escalate <= 1'b0;
    @(negedge clk_i);
    check_eq("error_o", error, FsmStateError);
    bus_read(9'd17, rerr, rdata, lat);
    check_eq("tlul_rerror_o", rerr, 2'b11);
    check_eq("rvalid latency", lat, 1);

    repeat (2) @(posedge clk_i);
    $display("Errors: %0d, timeouts: %0d", err_cnt, to_cnt);
    if (err_cnt == 0 && to_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule : tb_part_unbuf

//--- verilog.f
part_pkg.sv
part_fsm.sv
part_addr_gen.sv
part_init_capture.sv
part_access_ctrl.sv
part_unbuf_top.sv
otp_model.sv
tb_part_unbuf.sv
